// ==== exu_pkg.sv ====
package exu_pkg;

  // RV32 major opcodes.
  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_I      = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // ALU operations.
  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_XOR  = 4'd2;
  localparam logic [3:0] ALU_OR   = 4'd3;
  localparam logic [3:0] ALU_AND  = 4'd4;
  localparam logic [3:0] ALU_SLL  = 4'd5;
  localparam logic [3:0] ALU_SRL  = 4'd6;
  localparam logic [3:0] ALU_SLT  = 4'd7;
  localparam logic [3:0] ALU_SLTU = 4'd8;
  localparam logic [3:0] ALU_SLE  = 4'd9;
  localparam logic [3:0] ALU_SLEU = 4'd10;

  // SYSTEM funct3, held in imm[3:0] by decode.
  localparam logic [3:0] SYS_PRIV = 4'd0;
  localparam logic [3:0] CSRRW    = 4'd1;
  localparam logic [3:0] CSRRS    = 4'd2;
  localparam logic [3:0] CSRRC    = 4'd3;
  localparam logic [3:0] CSRRWI   = 4'd5;
  localparam logic [3:0] CSRRSI   = 4'd6;
  localparam logic [3:0] CSRRCI   = 4'd7;

  // funct12 of the privileged instructions, held in imm[15:4].
  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;

  localparam logic [11:0] CSR_MSTATUS  = 12'h300;
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;

  localparam int CAUSE_ECALL_M = 11; // Environment call from M-mode.

endpackage

// ==== exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  logic [3:0]      alu_op_i,
  output logic [XLEN-1:0] res_o
);
  import exu_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = src2_i[4:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign eq    = src1_i == src2_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  res_o = src1_i + src2_i;
      ALU_SUB:  res_o = src1_i - src2_i;
      ALU_XOR:  res_o = src1_i ^ src2_i;
      ALU_OR:   res_o = src1_i | src2_i;
      ALU_AND:  res_o = src1_i & src2_i;
      ALU_SLL:  res_o = src1_i << shamt;
      ALU_SRL:  res_o = src1_i >> shamt;
      ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_SLE:  res_o = {{(XLEN-1){1'b0}}, lt_s | eq};
      ALU_SLEU: res_o = {{(XLEN-1){1'b0}}, lt_u | eq};
      default:  res_o = '0;
    endcase
  end

endmodule

// ==== exu_csr_file.sv ====
`timescale 1ns/1ps

module exu_csr_file #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            wen_i,
  input  logic [11:0]     waddr_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic            ecall_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [11:0]     raddr_i,
  output logic [XLEN-1:0] rdata_o,
  output logic [XLEN-1:0] mepc_o,
  output logic [XLEN-1:0] mtvec_o
);
  import exu_pkg::*;

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] mscratch;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= '0;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mscratch <= '0;
    end else begin
      if (wen_i) begin
        case (waddr_i)
          CSR_MSTATUS:  mstatus  <= wdata_i;
          CSR_MTVEC:    mtvec    <= wdata_i;
          CSR_MEPC:     mepc     <= wdata_i;
          CSR_MCAUSE:   mcause   <= wdata_i;
          CSR_MSCRATCH: mscratch <= wdata_i;
          default: ; // Unimplemented address, write dropped.
        endcase
      end
      if (ecall_i) mepc <= pc_i; // Trap return address.
    end
  end

  always_comb begin
    case (raddr_i)
      CSR_MSTATUS:  rdata_o = mstatus;
      CSR_MTVEC:    rdata_o = mtvec;
      CSR_MEPC:     rdata_o = mepc;
      CSR_MCAUSE:   rdata_o = mcause;
      CSR_MSCRATCH: rdata_o = mscratch;
      default:      rdata_o = '0;
    endcase
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

endmodule

// ==== exu_mem.sv ====
`timescale 1ns/1ps

module exu_mem #(
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic            wen_i,
  output logic [XLEN-1:0] rdata_o,
  output logic            done_o
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic            req_q;
  logic            start;
  logic [AW-1:0]   idx;

  // One access per request, started on its rising edge.
  assign start = req_i & ~req_q;
  assign idx   = AW'(addr_i[XLEN-1:2] % MEM_WORDS);

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q  <= 1'b0;
      done_o <= 1'b0;
    end else begin
      req_q  <= req_i;
      done_o <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (start && wen_i) begin
      mem[idx] <= wdata_i;
    end
  end

  // Read word stays put until the next read.
  always_ff @(posedge clk) begin
    if (start && !wen_i) rdata_o <= mem[idx];
  end

endmodule

// ==== exu_stage.sv ====
`timescale 1ns/1ps

module exu_stage #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            prev_valid_i,
  input  logic            next_ready_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  logic [XLEN-1:0] op_j_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [3:0]      alu_op_i,
  input  logic [6:0]      opcode_i,
  input  logic [4:0]      rd_i,
  input  logic            rwen_i,
  input  logic            ren_i,
  input  logic            wen_i,
  output logic            lsu_req_o,
  output logic [XLEN-1:0] lsu_addr_o,
  output logic [XLEN-1:0] lsu_wdata_o,
  output logic            lsu_wen_o,
  input  logic [XLEN-1:0] mem_rdata_i,
  input  logic            mem_done_i,
  output logic [XLEN-1:0] alu_src1_o,
  output logic [XLEN-1:0] alu_src2_o,
  output logic [3:0]      alu_op_o,
  input  logic [XLEN-1:0] alu_res_i,
  output logic [11:0]     csr_addr_o,
  output logic            csr_wen_o,
  output logic [XLEN-1:0] csr_wdata_o,
  output logic            csr_ecall_o,
  output logic [XLEN-1:0] csr_pc_o,
  input  logic [XLEN-1:0] csr_rdata_i,
  input  logic [XLEN-1:0] mepc_i,
  input  logic [XLEN-1:0] mtvec_i,
  output logic            valid_o,
  output logic            ready_o,
  output logic [XLEN-1:0] reg_wdata_o,
  output logic [XLEN-1:0] npc_o,
  output logic [4:0]      rd_o,
  output logic            rwen_o,
  output logic            wben_o,
  output logic            ebreak_o
);
  import exu_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_EXEC, S_MEM, S_VALID} state_t;

  state_t          state;
  logic [XLEN-1:0] src1_q, src2_q, pc_q, target_q, ld_data_q;
  logic [15:0]     sys_q; // funct12 and funct3 of SYSTEM ops.
  logic [3:0]      alu_op_q;
  logic [6:0]      opcode_q;
  logic            ren_q, wen_q;
  logic [XLEN-1:0] pc_plus4;
  logic            is_sys, is_priv, is_ecall, is_mret, is_csr, taken, commit;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      lsu_req_o <= 1'b0;
      wben_o    <= 1'b0;
    end else begin
      wben_o <= 1'b0;
      case (state)
        S_IDLE: if (prev_valid_i) state <= S_EXEC;
        S_EXEC: begin
          if (ren_q || wen_q) begin
            lsu_req_o <= 1'b1;
            state     <= S_MEM;
          end else begin
            wben_o <= 1'b1;
            state  <= S_VALID;
          end
        end
        S_MEM: begin
          if (mem_done_i) begin
            lsu_req_o <= 1'b0;
            wben_o    <= 1'b1;
            state     <= S_VALID;
          end
        end
        default: if (next_ready_i) state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && prev_valid_i) begin
      src1_q   <= op1_i;
      src2_q   <= op2_i;
      pc_q     <= pc_i;
      target_q <= op_j_i + imm_i;
      sys_q    <= imm_i[15:0];
      alu_op_q <= alu_op_i;
      opcode_q <= opcode_i;
      rd_o     <= rd_i;
      rwen_o   <= rwen_i;
      ren_q    <= ren_i;
      wen_q    <= wen_i;
    end
    if (state == S_MEM && mem_done_i) ld_data_q <= mem_rdata_i;
  end

  assign valid_o  = state == S_VALID;
  assign ready_o  = state == S_IDLE;
  assign commit   = valid_o & next_ready_i; // CSR side effects land once, here.
  assign pc_plus4 = pc_q + XLEN'(4);

  assign is_sys   = opcode_q == OP_SYSTEM;
  assign is_priv  = is_sys && sys_q[3:0] == SYS_PRIV;
  assign is_ecall = is_priv && sys_q[15:4] == F12_ECALL;
  assign is_mret  = is_priv && sys_q[15:4] == F12_MRET;
  assign is_csr   = is_sys && !is_priv;
  assign ebreak_o = valid_o && is_priv && sys_q[15:4] == F12_EBREAK;

  assign alu_src1_o  = src1_q;
  assign alu_src2_o  = src2_q;
  assign alu_op_o    = alu_op_q;
  assign lsu_addr_o  = target_q;
  assign lsu_wdata_o = src2_q;
  assign lsu_wen_o   = wen_q;

  assign csr_addr_o  = is_ecall ? CSR_MCAUSE : is_mret ? CSR_MSTATUS : sys_q[15:4];
  assign csr_wen_o   = commit & (is_csr | is_ecall | is_mret);
  assign csr_ecall_o = commit & is_ecall;
  assign csr_pc_o    = pc_q;

  always_comb begin
    case (sys_q[3:0])
      CSRRS, CSRRSI: csr_wdata_o = csr_rdata_i | src1_q;
      CSRRC, CSRRCI: csr_wdata_o = csr_rdata_i & ~src1_q;
      SYS_PRIV: begin
        if (is_ecall) csr_wdata_o = XLEN'(CAUSE_ECALL_M);
        else csr_wdata_o = {csr_rdata_i[XLEN-1:8], 1'b1, csr_rdata_i[6:4],
                            csr_rdata_i[7], csr_rdata_i[2:0]}; // MIE <= MPIE.
      end
      default: csr_wdata_o = src1_q;
    endcase
  end

  // beq uses SUB and wants zero; the other compares want nonzero.
  assign taken = (alu_op_q == ALU_SUB) ? (alu_res_i == '0) : (alu_res_i != '0);

  always_comb begin
    npc_o = pc_plus4;
    case (opcode_q)
      OP_JAL, OP_JALR: npc_o = target_q;
      OP_BRANCH: if (taken) npc_o = target_q;
      OP_SYSTEM: begin
        if (is_ecall) npc_o = mtvec_i;
        else if (is_mret) npc_o = mepc_i;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (opcode_q)
      OP_LOAD:         reg_wdata_o = ld_data_q;
      OP_SYSTEM:       reg_wdata_o = csr_rdata_i; // Old CSR value.
      OP_JAL, OP_JALR: reg_wdata_o = pc_plus4;
      default:         reg_wdata_o = alu_res_i;
    endcase
  end

endmodule

// ==== exu_top.sv ====
`timescale 1ns/1ps

module exu_top #(
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            prev_valid_i,
  input  logic            next_ready_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  logic [XLEN-1:0] op_j_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [3:0]      alu_op_i,
  input  logic [6:0]      opcode_i,
  input  logic [4:0]      rd_i,
  input  logic            rwen_i,
  input  logic            ren_i,
  input  logic            wen_i,
  output logic            valid_o,
  output logic            ready_o,
  output logic [XLEN-1:0] reg_wdata_o,
  output logic [XLEN-1:0] npc_o,
  output logic [4:0]      rd_o,
  output logic            rwen_o,
  output logic            wben_o,
  output logic            ebreak_o
);

  logic [XLEN-1:0] alu_src1, alu_src2, alu_res;
  logic [3:0]      alu_op;
  logic            lsu_req, lsu_wen, mem_done;
  logic [XLEN-1:0] lsu_addr, lsu_wdata, mem_rdata;
  logic [11:0]     csr_addr;
  logic            csr_wen, csr_ecall;
  logic [XLEN-1:0] csr_wdata, csr_pc, csr_rdata, mepc, mtvec;

  exu_stage #(.XLEN(XLEN)) stage_i (
    .clk(clk), .rst(rst), .prev_valid_i(prev_valid_i), .next_ready_i(next_ready_i),
    .op1_i(op1_i), .op2_i(op2_i), .op_j_i(op_j_i), .imm_i(imm_i), .pc_i(pc_i),
    .alu_op_i(alu_op_i), .opcode_i(opcode_i), .rd_i(rd_i), .rwen_i(rwen_i),
    .ren_i(ren_i), .wen_i(wen_i),
    .lsu_req_o(lsu_req), .lsu_addr_o(lsu_addr), .lsu_wdata_o(lsu_wdata),
    .lsu_wen_o(lsu_wen), .mem_rdata_i(mem_rdata), .mem_done_i(mem_done),
    .alu_src1_o(alu_src1), .alu_src2_o(alu_src2), .alu_op_o(alu_op), .alu_res_i(alu_res),
    .csr_addr_o(csr_addr), .csr_wen_o(csr_wen), .csr_wdata_o(csr_wdata),
    .csr_ecall_o(csr_ecall), .csr_pc_o(csr_pc), .csr_rdata_i(csr_rdata),
    .mepc_i(mepc), .mtvec_i(mtvec),
    .valid_o(valid_o), .ready_o(ready_o), .reg_wdata_o(reg_wdata_o), .npc_o(npc_o),
    .rd_o(rd_o), .rwen_o(rwen_o), .wben_o(wben_o), .ebreak_o(ebreak_o)
  );

  exu_alu #(.XLEN(XLEN)) alu_i (
    .src1_i(alu_src1), .src2_i(alu_src2), .alu_op_i(alu_op), .res_o(alu_res)
  );

  // Same address serves the read and the general write port.
  exu_csr_file #(.XLEN(XLEN)) csr_i (
    .clk(clk), .rst(rst), .wen_i(csr_wen), .waddr_i(csr_addr), .wdata_i(csr_wdata),
    .ecall_i(csr_ecall), .pc_i(csr_pc), .raddr_i(csr_addr), .rdata_o(csr_rdata),
    .mepc_o(mepc), .mtvec_o(mtvec)
  );

  exu_mem #(.XLEN(XLEN), .MEM_WORDS(MEM_WORDS)) mem_i (
    .clk(clk), .rst(rst), .req_i(lsu_req), .addr_i(lsu_addr), .wdata_i(lsu_wdata),
    .wen_i(lsu_wen), .rdata_o(mem_rdata), .done_o(mem_done)
  );

endmodule

// ==== tb_exu_chk.sv ====
`timescale 1ns/1ps

module tb_exu_chk #(
  parameter int XLEN = 32
) (
  input logic            clk,
  input logic            rst,
  input logic            prev_valid_i,
  input logic            next_ready_i,
  input logic            valid_i,
  input logic            ready_i,
  input logic            lsu_req_i,
  input logic            wben_i,
  input logic            ebreak_i,
  input logic [XLEN-1:0] reg_wdata_i,
  input logic [XLEN-1:0] npc_i,
  input logic [4:0]      res_rd_i
);

  int fails = 0;

  // A held result keeps every output.
  hold_a: assert property (@(posedge clk) disable iff (rst)
    valid_i && !next_ready_i |=> valid_i && $stable(reg_wdata_i) && $stable(npc_i)
      && $stable(res_rd_i) && $stable(ebreak_i))
    else begin
      fails++;
      $error("result outputs changed while held by next_ready_i");
    end

  busy_a: assert property (@(posedge clk) disable iff (rst)
    valid_i || lsu_req_i |-> !ready_i)
    else begin
      fails++;
      $error("ready_o high while the stage is busy");
    end

  accept_a: assert property (@(posedge clk) disable iff (rst)
    prev_valid_i && ready_i |=> !ready_i)
    else begin
      fails++;
      $error("ready_o stayed high after an instruction was accepted");
    end

  wben_first_a: assert property (@(posedge clk) disable iff (rst)
    wben_i |-> valid_i && !$past(valid_i))
    else begin
      fails++;
      $error("wben_o high outside the first valid cycle");
    end

  wben_rise_a: assert property (@(posedge clk) disable iff (rst)
    $rose(valid_i) |-> wben_i)
    else begin
      fails++;
      $error("wben_o missing in the first valid cycle");
    end

  reset_a: assert property (@(posedge clk)
    rst |=> !valid_i && !lsu_req_i && !wben_i && !ebreak_i && ready_i)
    else begin
      fails++;
      $error("outputs not idle after reset");
    end

endmodule

// ==== tb_exu_monitor.sv ====
`timescale 1ns/1ps

module tb_exu_monitor #(
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            prev_valid_i,
  input  logic            next_ready_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  logic [XLEN-1:0] op_j_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [3:0]      alu_op_i,
  input  logic [6:0]      opcode_i,
  input  logic [4:0]      rd_i,
  input  logic            rwen_i,
  input  logic            ready_i,
  input  logic            valid_i,
  input  logic            wben_i,
  input  logic            ebreak_i,
  input  logic [XLEN-1:0] reg_wdata_i,
  input  logic [XLEN-1:0] npc_i,
  input  logic [4:0]      res_rd_i,
  input  logic            res_rwen_i,
  output int              errors_o,
  output int              results_o
);
  import exu_pkg::*;

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [XLEN-1:0] mstatus, mtvec, mepc, mcause, mscratch;
  logic [XLEN-1:0] a_q, b_q, tgt_q, pc_q, imm_q;
  logic [3:0]      aop_q;
  logic [6:0]      opc_q;
  logic [4:0]      rd_q;
  logic            rwen_q;
  int              wben_cnt;

  function automatic logic [XLEN-1:0] alu_model(logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                                                logic [3:0] op);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
      ALU_SLTU: return (a < b) ? 1 : 0;
      ALU_SLE:  return ($signed(a) <= $signed(b)) ? 1 : 0;
      ALU_SLEU: return (a <= b) ? 1 : 0;
      default:  return '0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] csr_read(logic [11:0] addr);
    case (addr)
      CSR_MSTATUS:  return mstatus;
      CSR_MTVEC:    return mtvec;
      CSR_MEPC:     return mepc;
      CSR_MCAUSE:   return mcause;
      CSR_MSCRATCH: return mscratch;
      default:      return '0; // Unimplemented reads as zero.
    endcase
  endfunction

  task automatic csr_write(logic [11:0] addr, logic [XLEN-1:0] data);
    case (addr)
      CSR_MSTATUS:  mstatus = data;
      CSR_MTVEC:    mtvec = data;
      CSR_MEPC:     mepc = data;
      CSR_MCAUSE:   mcause = data;
      CSR_MSCRATCH: mscratch = data;
      default: ;
    endcase
  endtask

  task automatic compare(string name, string field, logic [XLEN-1:0] exp,
                         logic [XLEN-1:0] act);
    if (exp !== act) begin
      errors_o++;
      $display("[ERROR] %s %s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  task automatic retire();
    logic [XLEN-1:0] exp_wd, exp_npc, pc4, res, old;
    logic [11:0]     addr, f12;
    logic [3:0]      f3;
    logic            exp_eb;
    string           name;
    int              idx;
    pc4     = pc_q + 4;
    res     = alu_model(a_q, b_q, aop_q);
    f3      = imm_q[3:0];
    f12     = imm_q[15:4];
    idx     = tgt_q[XLEN-1:2] % MEM_WORDS; // Word address wraps on the depth.
    exp_wd  = res;
    exp_npc = pc4;
    exp_eb  = 1'b0;
    name    = "alu_reg";
    case (opc_q)
      OP_I: name = "alu_imm";
      OP_BRANCH: begin
        name = "branch";
        if ((aop_q == ALU_SUB) ? (res == '0) : (res != '0)) exp_npc = tgt_q;
      end
      OP_JAL, OP_JALR: begin
        name    = "jump";
        exp_wd  = pc4;
        exp_npc = tgt_q;
      end
      OP_LOAD: begin
        name   = "load";
        exp_wd = mem[idx];
      end
      OP_STORE: begin
        name     = "store";
        mem[idx] = b_q;
      end
      OP_SYSTEM: begin
        name = "csr";
        addr = f12;
        if (f3 == SYS_PRIV) addr = (f12 == F12_ECALL) ? CSR_MCAUSE :
                                   (f12 == F12_MRET) ? CSR_MSTATUS : f12;
        old    = csr_read(addr);
        exp_wd = old;
        case (f3)
          SYS_PRIV: begin
            if (f12 == F12_ECALL) begin
              name    = "ecall";
              exp_npc = mtvec;
              mcause  = CAUSE_ECALL_M;
              mepc    = pc_q;
            end else if (f12 == F12_MRET) begin
              name       = "mret";
              exp_npc    = mepc;
              mstatus[3] = mstatus[7];
              mstatus[7] = 1'b1;
            end else if (f12 == F12_EBREAK) begin
              name   = "ebreak";
              exp_eb = 1'b1;
            end
          end
          CSRRW, CSRRWI: csr_write(addr, a_q);
          CSRRS, CSRRSI: csr_write(addr, old | a_q);
          CSRRC, CSRRCI: csr_write(addr, old & ~a_q);
          default: ;
        endcase
      end
      default: ;
    endcase
    compare(name, "reg_wdata", exp_wd, reg_wdata_i);
    compare(name, "npc", exp_npc, npc_i);
    compare(name, "rd", XLEN'(rd_q), XLEN'(res_rd_i));
    compare(name, "rwen", XLEN'(rwen_q), XLEN'(res_rwen_i));
    compare(name, "ebreak", XLEN'(exp_eb), XLEN'(ebreak_i));
    compare(name, "wben pulses", 1, XLEN'(wben_cnt));
    results_o++;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) mem[i] = '0;
      {mstatus, mtvec, mepc, mcause, mscratch} = '0;
      errors_o  = 0;
      results_o = 0;
      wben_cnt  = 0;
    end else begin
      if (wben_i) wben_cnt++;
      if (prev_valid_i && ready_i) begin
        a_q      = op1_i;
        b_q      = op2_i;
        tgt_q    = op_j_i + imm_i; // Branch, jump and memory target.
        pc_q     = pc_i;
        imm_q    = imm_i;
        aop_q    = alu_op_i;
        opc_q    = opcode_i;
        rd_q     = rd_i;
        rwen_q   = rwen_i;
        wben_cnt = 0;
      end
      if (valid_i && next_ready_i) retire();
    end
  end

endmodule

// ==== tb_exu.sv ====
`timescale 1ns/1ps

module tb_exu;
  import exu_pkg::*;

  localparam int XLEN      = 32;
  localparam int MEM_WORDS = 64;
  localparam int TIMEOUT   = 40;

  logic            clk, rst, prev_valid_i, next_ready_i, rwen_i, ren_i, wen_i;
  logic [XLEN-1:0] op1_i, op2_i, op_j_i, imm_i, pc_i;
  logic [3:0]      alu_op_i;
  logic [6:0]      opcode_i;
  logic [4:0]      rd_i, rd_o;
  logic            valid_o, ready_o, rwen_o, wben_o, ebreak_o;
  logic [XLEN-1:0] reg_wdata_o, npc_o;
  logic [31:0]     lfsr;
  logic            aborted;
  logic [XLEN-1:0] a, b, j, im;
  int              issued, mon_errors, mon_results, total;

  logic [3:0] cmp_ops [5] = '{ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SLE, ALU_SLEU};
  logic [3:0] csr_ops [6] = '{CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};

  exu_top #(.XLEN(XLEN), .MEM_WORDS(MEM_WORDS)) exu_top_i (.*);

  tb_exu_monitor #(.XLEN(XLEN), .MEM_WORDS(MEM_WORDS)) monitor_i (
    .ready_i(ready_o), .valid_i(valid_o), .wben_i(wben_o), .ebreak_i(ebreak_o),
    .reg_wdata_i(reg_wdata_o), .npc_i(npc_o), .res_rd_i(rd_o), .res_rwen_i(rwen_o),
    .errors_o(mon_errors), .results_o(mon_results), .*
  );

  bind exu_stage tb_exu_chk #(.XLEN(XLEN)) chk_i (
    .clk(clk), .rst(rst), .prev_valid_i(prev_valid_i), .next_ready_i(next_ready_i),
    .valid_i(valid_o), .ready_i(ready_o), .lsu_req_i(lsu_req_o), .wben_i(wben_o),
    .ebreak_i(ebreak_o), .reg_wdata_i(reg_wdata_o), .npc_i(npc_o), .res_rd_i(rd_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1; // Taps 32, 22, 2, 1.
  endfunction

  function automatic logic [31:0] next_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Issues one instruction and waits until its result is taken downstream.
  task automatic issue(input logic [6:0] opc, input logic [3:0] aop,
                       input logic [XLEN-1:0] s1, s2, base, ofs);
    int   cycles;
    logic done;
    if (aborted) return;
    cycles = 0;
    while (!ready_o) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout: the stage never became ready for a new instruction.");
        aborted = 1'b1;
        return;
      end
    end
    {opcode_i, alu_op_i, op1_i, op2_i, op_j_i, imm_i} = {opc, aop, s1, s2, base, ofs};
    pc_i         = {30'(next_bits(30)), 2'b00};
    rd_i         = 5'(next_bits(5));
    rwen_i       = opc != OP_STORE && opc != OP_BRANCH;
    ren_i        = opc == OP_LOAD;
    wen_i        = opc == OP_STORE;
    prev_valid_i = 1'b1;
    @(negedge clk);
    prev_valid_i = 1'b0;
    issued++;
    done   = 1'b0;
    cycles = 0;
    while (!done) begin
      next_ready_i = next_bits(2) != 2'b00; // Held back about a quarter of the time.
      done         = valid_o && next_ready_i;
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout: no result was taken for opcode %b.", opc);
        aborted = 1'b1;
        return;
      end
    end
  endtask

  initial begin
    lfsr = 32'd59871;
    {rst, prev_valid_i, next_ready_i, rwen_i, ren_i, wen_i} = 6'b100000;
    {op1_i, op2_i, op_j_i, imm_i, pc_i} = '0;
    {alu_op_i, opcode_i, rd_i} = '0;
    aborted = 1'b0;
    issued  = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    repeat (30) begin
      a  = next_bits(32);
      b  = next_bits(32);
      im = next_bits(4) % 11;
      issue(next_bits(1) ? OP_R : OP_I, im[3:0], a, b, '0, next_bits(32));
    end
    repeat (20) begin
      a  = next_bits(32);
      b  = next_bits(1) ? a : next_bits(32); // Equal operands half the time.
      j  = next_bits(32);
      im = next_bits(12);
      issue(OP_BRANCH, cmp_ops[next_bits(3) % 5], a, b, j, im);
    end
    repeat (6) begin
      j  = next_bits(32);
      im = next_bits(20);
      issue(next_bits(1) ? OP_JAL : OP_JALR, ALU_ADD, next_bits(32), '0, j, im);
    end

    // Stores go to the lower half of the memory, so the upper half stays zero.
    repeat (12) begin
      j  = {24'(next_bits(24)), 1'b0, 5'(next_bits(5)), 2'b00};
      im = next_bits(8);
      b  = next_bits(32);
      issue(OP_STORE, ALU_ADD, next_bits(32), b, j - im, im);
      issue(OP_LOAD, ALU_ADD, '0, '0, j, '0);
    end
    repeat (4) begin
      j = {24'(next_bits(24)), 1'b1, 5'(next_bits(5)), 2'b00};
      issue(OP_LOAD, ALU_ADD, '0, '0, j, '0);
    end

    repeat (10) begin
      a = next_bits(32);
      issue(OP_SYSTEM, ALU_ADD, a, '0, '0, {16'h0, CSR_MSCRATCH, csr_ops[next_bits(3) % 6]});
    end

    issue(OP_SYSTEM, ALU_ADD, {30'(next_bits(30)), 2'b00}, '0, '0, {16'h0, CSR_MTVEC, CSRRW});
    issue(OP_SYSTEM, ALU_ADD, '0, '0, '0, {16'h0, F12_ECALL, SYS_PRIV});
    issue(OP_SYSTEM, ALU_ADD, '0, '0, '0, {16'h0, CSR_MEPC, CSRRS});
    issue(OP_SYSTEM, ALU_ADD, '0, '0, '0, {16'h0, CSR_MCAUSE, CSRRS});
    issue(OP_SYSTEM, ALU_ADD, 32'h80, '0, '0, {16'h0, CSR_MSTATUS, CSRRS}); // Set MPIE.
    issue(OP_SYSTEM, ALU_ADD, '0, '0, '0, {16'h0, F12_MRET, SYS_PRIV});
    issue(OP_SYSTEM, ALU_ADD, '0, '0, '0, {16'h0, CSR_MSTATUS, CSRRS});
    issue(OP_SYSTEM, ALU_ADD, '0, '0, '0, {16'h0, F12_EBREAK, SYS_PRIV});

    total = mon_errors + exu_top_i.stage_i.chk_i.fails + int'(aborted);
    if (mon_results != issued) begin
      $display("The monitor saw %0d results for %0d issued instructions.", mon_results, issued);
      total++;
    end
    $display("Issued %0d, model errors %0d, assertion failures %0d, timeouts %0d",
             issued, mon_errors, exu_top_i.stage_i.chk_i.fails, int'(aborted));
    if (total == 0) $display("Simulation passed");
    else $display("Simulation failed");
    $finish;
  end

endmodule

// ==== sim.f ====
exu_pkg.sv
exu_alu.sv
exu_csr_file.sv
exu_mem.sv
exu_stage.sv
exu_top.sv
tb_exu_chk.sv
tb_exu_monitor.sv
tb_exu.sv
